//--- source/closCfgPkg.sv
// Fixed dimensions of the three-stage Clos network and the widths derived
// from them. Imported by the type package and by the RTL modules.

package closCfgPkg;

  ////////////////////////////////////////////////////////////////////////////
  // endpoint counts
  ////////////////////////////////////////////////////////////////////////////

  // masters on the ingress side
  localparam int unsigned NumMasters = 4;
  // memory banks on the egress side
  localparam int unsigned NumBanks = 4;

  ////////////////////////////////////////////////////////////////////////////
  // clos dimensions with n = 2, m = 2, r = 2
  ////////////////////////////////////////////////////////////////////////////

  // banks behind one egress node
  localparam int unsigned ClosN = 2;
  // middle switches, equal to the links per ingress node
  localparam int unsigned ClosM = 2;
  // ingress nodes, also the number of egress nodes
  localparam int unsigned ClosR = 2;
  // masters sharing one ingress node
  localparam int unsigned NumInNode = NumMasters / ClosR;

  ////////////////////////////////////////////////////////////////////////////
  // widths
  ////////////////////////////////////////////////////////////////////////////

  localparam int unsigned DataWidth = 32;
  // upper bit picks the egress node, lower bit the bank in it
  localparam int unsigned BankAddrWidth = $clog2(NumBanks);
  // one counter bit for each stage
  localparam int unsigned PrioWidth = $clog2(ClosM * ClosR * NumInNode);

endpackage

//--- source/closTypesPkg.sv
// Vector types and the request and response link structs shared by all
// stages of the Clos network.

package closTypesPkg;

  ////////////////////////////////////////////////////////////////////////////
  // plain vectors
  ////////////////////////////////////////////////////////////////////////////

  // full bank address as seen by a master
  typedef logic [closCfgPkg::BankAddrWidth-1:0] bankAddrT;

  // address slice one stage routes on, also used for port indices
  typedef logic [$clog2(closCfgPkg::ClosR)-1:0] nodeAddrT;

  // request and response payload
  typedef logic [closCfgPkg::DataWidth-1:0] dataT;

  // shared arbitration counter
  typedef logic [closCfgPkg::PrioWidth-1:0] prioT;

  ////////////////////////////////////////////////////////////////////////////
  // link bundles
  ////////////////////////////////////////////////////////////////////////////

  // request heading toward the banks
  // address stays whole, each stage reads its own bit
  typedef struct packed {
    logic     req;
    bankAddrT addr;
    dataT     wdata;
  } linkReqT;

  // response heading back toward the masters
  typedef struct packed {
    logic vld;
    dataT rdata;
  } linkRspT;

endpackage

//--- source/priorityCounter.sv
// Shared priority counter of the Clos network. Advances on every bank
// handshake and hands one bit to each stage as its arbitration priority.
`timescale 1ns/1ps

module priorityCounter (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // any bank took a request this cycle
  input  logic                  handshake_i,
  output closTypesPkg::nodeAddrT egrPrio_o,
  output closTypesPkg::nodeAddrT midPrio_o,
  output closTypesPkg::nodeAddrT ingPrio_o,
  // ingress mapping of the previous cycle, for returning responses
  output closTypesPkg::nodeAddrT ingRspPrio_o
);

  import closCfgPkg::*;
  import closTypesPkg::*;

  prioT     cntQ;
  nodeAddrT ingPrioQ;

  // locked counter so all nodes of a stage agree on priority
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cntQ     <= '0;
      ingPrioQ <= '0;
    end else begin
      if (handshake_i) begin
        cntQ <= cntQ + prioT'(1);
      end
      // responses arrive one cycle after the grant
      ingPrioQ <= cntQ[PrioWidth-1];
    end
  end

  // lsb toggles fastest, egress sees the most rotation
  assign egrPrio_o    = cntQ[0];
  assign midPrio_o    = cntQ[1];
  // msb swaps the master to link mapping
  assign ingPrio_o    = cntQ[PrioWidth-1];
  assign ingRspPrio_o = ingPrioQ;

endmodule

//--- source/ingressNode.sv
// Ingress stage node. Spreads its masters over the middle links by a
// permutation chosen by the priority bit, so the node itself never blocks.
`timescale 1ns/1ps

module ingressNode (
  // master side
  input  closTypesPkg::linkReqT [closCfgPkg::NumInNode-1:0] mstReq_i,
  output logic                  [closCfgPkg::NumInNode-1:0] mstGnt_o,
  output closTypesPkg::linkRspT [closCfgPkg::NumInNode-1:0] mstRsp_o,
  // middle switch side
  output closTypesPkg::linkReqT [closCfgPkg::ClosM-1:0]     linkReq_o,
  input  logic                  [closCfgPkg::ClosM-1:0]     linkGnt_i,
  input  closTypesPkg::linkRspT [closCfgPkg::ClosM-1:0]     linkRsp_i,
  // mapping select for requests and grants
  input  closTypesPkg::nodeAddrT                            prio_i,
  // mapping that was used by the requests now being answered
  input  closTypesPkg::nodeAddrT                            rspPrio_i
);

  import closCfgPkg::*;
  import closTypesPkg::*;

  ////////////////////////////////////////////////////////////////////////////
  // permutation
  ////////////////////////////////////////////////////////////////////////////

  // link used by master k, also master on link k since xor is its own inverse
  nodeAddrT [NumInNode-1:0] reqSel;
  // same mapping, one cycle old
  nodeAddrT [NumInNode-1:0] rspSel;

  for (genvar k = 0; k < NumInNode; k++) begin : gSel
    assign reqSel[k] = nodeAddrT'(k) ^ prio_i;
    assign rspSel[k] = nodeAddrT'(k) ^ rspPrio_i;
  end

  ////////////////////////////////////////////////////////////////////////////
  // request, grant and response routing
  ////////////////////////////////////////////////////////////////////////////

  for (genvar k = 0; k < NumInNode; k++) begin : gRoute
    // link k carries the master mapped onto it
    assign linkReq_o[k] = mstReq_i[reqSel[k]];

    // grant comes back over the link the master used this cycle
    assign mstGnt_o[k]  = linkGnt_i[reqSel[k]];

    // middle switch already set vld only on the link it granted
    assign mstRsp_o[k]  = linkRsp_i[rspSel[k]];
  end

endmodule

//--- source/crossbarNode.sv
// 2x2 address routed switch used for the middle and egress stages.
// Grants are combinational; the winner per output is registered so the
// response can be returned to it one cycle later.
`timescale 1ns/1ps

module crossbarNode #(
  // request address bit this stage routes on
  parameter int unsigned AddrBit = 0
) (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  // input side, toward the masters
  input  closTypesPkg::linkReqT [1:0]  inReq_i,
  output logic                  [1:0]  inGnt_o,
  output closTypesPkg::linkRspT [1:0]  inRsp_o,
  // output side, toward the banks
  output closTypesPkg::linkReqT [1:0]  outReq_o,
  input  logic                  [1:0]  outGnt_i,
  input  closTypesPkg::linkRspT [1:0]  outRsp_i,
  // input index that wins a tie
  input  closTypesPkg::nodeAddrT       prio_i
);

  import closCfgPkg::*;
  import closTypesPkg::*;

  // match[o][i] set when input i requests output o
  logic     [1:0][1:0] match;
  // selected input per output
  nodeAddrT [1:0]      win;
  // request accepted downstream per output
  logic     [1:0]      outHs;

  // return path state
  nodeAddrT [1:0]      rspSelQ;
  logic     [1:0]      rspVldQ;

  ////////////////////////////////////////////////////////////////////////////
  // arbitration
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    for (int o = 0; o < 2; o++) begin
      for (int i = 0; i < 2; i++) begin
        match[o][i] = inReq_i[i].req && (inReq_i[i].addr[AddrBit] == nodeAddrT'(o));
      end

      // contention goes to the priority input
      if (&match[o]) begin
        win[o] = prio_i;
      end else begin
        // lone or no requester
        win[o] = nodeAddrT'(match[o][1]);
      end

      // payload follows the winner, req only when someone asked
      outReq_o[o]     = inReq_i[win[o]];
      outReq_o[o].req = |match[o];
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // grant return
  ////////////////////////////////////////////////////////////////////////////

  // an input targets one output at most, so at most one term is set
  always_comb begin
    inGnt_o = '0;
    for (int o = 0; o < 2; o++) begin
      for (int i = 0; i < 2; i++) begin
        if (match[o][i] && (win[o] == nodeAddrT'(i))) begin
          inGnt_o[i] = inGnt_o[i] | outGnt_i[o];
        end
      end
    end
  end

  for (genvar o = 0; o < 2; o++) begin : gHs
    assign outHs[o] = outReq_o[o].req & outGnt_i[o];
  end

  ////////////////////////////////////////////////////////////////////////////
  // response return
  ////////////////////////////////////////////////////////////////////////////

  // remember who got through, valid for one cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rspVldQ <= '0;
      rspSelQ <= '0;
    end else begin
      rspVldQ <= outHs;
      for (int o = 0; o < 2; o++) begin
        if (outHs[o]) begin
          rspSelQ[o] <= win[o];
        end
      end
    end
  end

  // steer each output's response to the input it served last cycle
  always_comb begin
    inRsp_o = '0;
    for (int o = 0; o < 2; o++) begin
      for (int i = 0; i < 2; i++) begin
        if (rspVldQ[o] && (rspSelQ[o] == nodeAddrT'(i))) begin
          inRsp_o[i].vld   = outRsp_i[o].vld;
          inRsp_o[i].rdata = outRsp_i[o].rdata;
        end
      end
    end
  end

endmodule

//--- source/closNet.sv
// Top level of the 4x4 Clos interconnect. Packs master ports into link
// structs and wires ingress, middle and egress stages to the banks.
`timescale 1ns/1ps

module closNet (
  input  logic                                              clk_i,
  input  logic                                              rst_ni,
  // master side
  input  logic                  [closCfgPkg::NumMasters-1:0] req_i,
  input  closTypesPkg::bankAddrT [closCfgPkg::NumMasters-1:0] addr_i,
  input  closTypesPkg::dataT    [closCfgPkg::NumMasters-1:0] wdata_i,
  output logic                  [closCfgPkg::NumMasters-1:0] gnt_o,
  output logic                  [closCfgPkg::NumMasters-1:0] vld_o,
  output closTypesPkg::dataT    [closCfgPkg::NumMasters-1:0] rdata_o,
  // bank side
  input  logic                  [closCfgPkg::NumBanks-1:0]   gnt_i,
  input  closTypesPkg::dataT    [closCfgPkg::NumBanks-1:0]   rdata_i,
  output logic                  [closCfgPkg::NumBanks-1:0]   req_o,
  output closTypesPkg::dataT    [closCfgPkg::NumBanks-1:0]   wdata_o
);

  import closCfgPkg::*;
  import closTypesPkg::*;

  // master bundles
  linkReqT [NumMasters-1:0] mstReq;
  linkRspT [NumMasters-1:0] mstRsp;

  // ingress view [node][link]
  linkReqT [ClosR-1:0][ClosM-1:0] ingReq;
  logic    [ClosR-1:0][ClosM-1:0] ingGnt;
  linkRspT [ClosR-1:0][ClosM-1:0] ingRsp;

  // middle view [switch][port]
  linkReqT [ClosM-1:0][ClosR-1:0] midOutReq;
  logic    [ClosM-1:0][ClosR-1:0] midInGnt;
  logic    [ClosM-1:0][ClosR-1:0] midOutGnt;
  linkRspT [ClosM-1:0][ClosR-1:0] midInRsp;
  linkRspT [ClosM-1:0][ClosR-1:0] midOutRsp;

  // egress view [node][port]
  linkReqT [ClosR-1:0][ClosM-1:0] egrInReq;
  logic    [ClosR-1:0][ClosM-1:0] egrInGnt;
  linkRspT [ClosR-1:0][ClosM-1:0] egrInRsp;
  linkReqT [ClosR-1:0][ClosN-1:0] egrOutReq;
  linkRspT [ClosR-1:0][ClosN-1:0] egrOutRsp;

  nodeAddrT egrPrio, midPrio, ingPrio, ingRspPrio;

  for (genvar k = 0; k < NumMasters; k++) begin : gMst
    assign mstReq[k] = '{req: req_i[k], addr: addr_i[k], wdata: wdata_i[k]};
    assign vld_o[k]   = mstRsp[k].vld;
    assign rdata_o[k] = mstRsp[k].rdata;
  end

  ////////////////////////////////////////////////////////////////////////////
  // stage interconnect, links are transposed between stages
  ////////////////////////////////////////////////////////////////////////////

  for (genvar m = 0; m < ClosM; m++) begin : gLinkM
    for (genvar r = 0; r < ClosR; r++) begin : gLinkR
      assign ingGnt[r][m]    = midInGnt[m][r];
      assign ingRsp[r][m]    = midInRsp[m][r];
      assign egrInReq[r][m]  = midOutReq[m][r];
      assign midOutGnt[m][r] = egrInGnt[r][m];
      assign midOutRsp[m][r] = egrInRsp[r][m];
    end
  end

  // bank index is egress node times ClosN plus port
  for (genvar r = 0; r < ClosR; r++) begin : gBankR
    for (genvar n = 0; n < ClosN; n++) begin : gBankN
      assign req_o[r*ClosN+n]   = egrOutReq[r][n].req;
      assign wdata_o[r*ClosN+n] = egrOutReq[r][n].wdata;
      // egress return register decides validity
      assign egrOutRsp[r][n]    = '{vld: 1'b1, rdata: rdata_i[r*ClosN+n]};
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // stages
  ////////////////////////////////////////////////////////////////////////////

  priorityCounter iPrioCnt (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .handshake_i  (|(req_o & gnt_i)),
    .egrPrio_o    (egrPrio),
    .midPrio_o    (midPrio),
    .ingPrio_o    (ingPrio),
    .ingRspPrio_o (ingRspPrio)
  );

  for (genvar r = 0; r < ClosR; r++) begin : gIngress
    ingressNode iIngress (
      .mstReq_i  (mstReq[NumInNode*r +: NumInNode]),
      .mstGnt_o  (gnt_o[NumInNode*r +: NumInNode]),
      .mstRsp_o  (mstRsp[NumInNode*r +: NumInNode]),
      .linkReq_o (ingReq[r]),
      .linkGnt_i (ingGnt[r]),
      .linkRsp_i (ingRsp[r]),
      .prio_i    (ingPrio),
      .rspPrio_i (ingRspPrio)
    );
  end

  // middle routes on the egress node bit of the address
  for (genvar m = 0; m < ClosM; m++) begin : gMiddle
    linkReqT [ClosR-1:0] midInReq;

    for (genvar r = 0; r < ClosR; r++) begin : gIn
      assign midInReq[r] = ingReq[r][m];
    end

    crossbarNode #(.AddrBit(1)) iMiddle (
      .clk_i    (clk_i),
      .rst_ni   (rst_ni),
      .inReq_i  (midInReq),
      .inGnt_o  (midInGnt[m]),
      .inRsp_o  (midInRsp[m]),
      .outReq_o (midOutReq[m]),
      .outGnt_i (midOutGnt[m]),
      .outRsp_i (midOutRsp[m]),
      .prio_i   (midPrio)
    );
  end

  // egress routes on the bank bit within the node
  for (genvar r = 0; r < ClosR; r++) begin : gEgress
    crossbarNode #(.AddrBit(0)) iEgress (
      .clk_i    (clk_i),
      .rst_ni   (rst_ni),
      .inReq_i  (egrInReq[r]),
      .inGnt_o  (egrInGnt[r]),
      .inRsp_o  (egrInRsp[r]),
      .outReq_o (egrOutReq[r]),
      .outGnt_i (gnt_i[ClosN*r +: ClosN]),
      .outRsp_i (egrOutRsp[r]),
      .prio_i   (egrPrio)
    );
  end

endmodule

//--- sim/closNet_props.sv
// Concurrent checks on the top-level timing of the Clos interconnect.
// Attached to every closNet instance by the bind at the end of this file.
`timescale 1ns/1ps

module closNet_props (
  input logic                                clk_i,
  input logic                                rst_ni,
  input logic [closCfgPkg::NumMasters-1:0]   req_i,
  input logic [closCfgPkg::NumMasters-1:0]   gnt_o,
  input logic [closCfgPkg::NumMasters-1:0]   vld_o,
  input logic [closCfgPkg::NumBanks-1:0]     req_o,
  input logic [closCfgPkg::NumBanks-1:0]     gnt_i
);

  // response strobe is the grant delayed by exactly one cycle
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    vld_o == $past(gnt_o))
    else $error("vld_o does not follow gnt_o by one cycle");

  // no grant without a request
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (gnt_o & ~req_i) == '0)
    else $error("gnt_o high for a master with req_i low");

  // one master grant for each bank handshake
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    $countones(req_o & gnt_i) == $countones(gnt_o))
    else $error("bank handshakes and master grants differ in number");

endmodule

bind closNet closNet_props iProps (.*);

//--- sim/closNetTb.sv
// Testbench of the Clos interconnect. Drives directed and random master
// traffic, models the banks and checks grants, bank requests and responses.
`timescale 1ns/1ps

module closNetTb;

  import closCfgPkg::*;
  import closTypesPkg::*;

  localparam int unsigned ResetCycles = 4;
  localparam int unsigned IdleCycles  = 8;
  localparam int unsigned LoneCycles  = NumMasters * NumBanks + 1;
  localparam int unsigned RandCycles  = 500;
  localparam int unsigned BlockCycles = NumBanks * 50;
  localparam int unsigned TotalCycles =
    ResetCycles + IdleCycles + LoneCycles + RandCycles + BlockCycles;
  // 100 ns per cycle plus slack
  localparam int unsigned WatchdogNs  = TotalCycles * 100 + 2000;

  logic                  clk = 1'b0;
  logic                  rstN;
  logic [NumMasters-1:0] req, gnt, vld;
  bankAddrT [NumMasters-1:0] addr;
  dataT [NumMasters-1:0] wdata, rdata;
  logic [NumBanks-1:0]   bankGnt, bankReq;
  dataT [NumBanks-1:0]   bankRdata, bankWdata;

  // model state
  logic [NumMasters-1:0]     prevGnt;
  bankAddrT [NumMasters-1:0] prevAddr;
  logic [23:0]               rspCnt;
  int unsigned errCnt, testErrStart, gntTotal, hsTotal;

  always #50 clk = ~clk;

  closNet UUT (
    .clk_i   (clk),
    .rst_ni  (rstN),
    .req_i   (req),
    .addr_i  (addr),
    .wdata_i (wdata),
    .gnt_o   (gnt),
    .vld_o   (vld),
    .rdata_o (rdata),
    .gnt_i   (bankGnt),
    .rdata_i (bankRdata),
    .req_o   (bankReq),
    .wdata_o (bankWdata)
  );

  ////////////////////////////////////////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic checkFlag(string name, logic expV, logic actV);
    if (actV !== expV) begin
      errCnt++;
      $display("ERROR %0t %s expected %b got %b", $time, name, expV, actV);
    end
  endtask

  task automatic checkData(string name, dataT expV, dataT actV);
    if (actV !== expV) begin
      errCnt++;
      $display("ERROR %0t %s expected %h got %h", $time, name, expV, actV);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // one cycle: drive on the falling edge, check just before the rising edge
  ////////////////////////////////////////////////////////////////////////////

  task automatic stepCycle(input logic [NumMasters-1:0] reqV,
                           input bankAddrT [NumMasters-1:0] addrV,
                           input dataT [NumMasters-1:0] wdataV,
                           input logic [NumBanks-1:0] gntV,
                           input logic [NumMasters-1:0] mustGnt);
    int       hits [NumBanks];
    logic     anyReq;
    bankAddrT b;

    @(negedge clk);
    req     = reqV;
    addr    = addrV;
    wdata   = wdataV;
    bankGnt = gntV;
    // per-bank tag in the upper byte, running count below
    for (int k = 0; k < NumBanks; k++) begin
      bankRdata[k] = {8'(8'hA0 + k), rspCnt};
    end
    rspCnt = rspCnt + 24'd1;
    #40;

    for (int k = 0; k < NumBanks; k++) begin
      hits[k] = 0;
    end
    for (int m = 0; m < NumMasters; m++) begin
      b = addr[m];
      // response of last cycle's grant
      checkFlag($sformatf("vld_o[%0d]", m), prevGnt[m], vld[m]);
      if (prevGnt[m] && vld[m]) begin
        checkData($sformatf("rdata_o[%0d]", m), bankRdata[prevAddr[m]], rdata[m]);
      end
      if (!req[m] || !bankGnt[b]) begin
        checkFlag($sformatf("gnt_o[%0d]", m), 1'b0, gnt[m]);
      end else if (mustGnt[m]) begin
        checkFlag($sformatf("gnt_o[%0d]", m), 1'b1, gnt[m]);
      end
      if (gnt[m]) begin
        hits[b]++;
        checkData($sformatf("wdata_o[%0d]", b), wdata[m], bankWdata[b]);
      end
    end
    for (int k = 0; k < NumBanks; k++) begin
      anyReq = 1'b0;
      for (int m = 0; m < NumMasters; m++) begin
        anyReq |= req[m] && (addr[m] == bankAddrT'(k));
      end
      if (!anyReq) begin
        checkFlag($sformatf("req_o[%0d]", k), 1'b0, bankReq[k]);
      end
      if (hits[k] > 1) begin
        errCnt++;
        $display("bank %0d handed to %0d masters in one cycle at %0t", k, hits[k], $time);
      end
      checkFlag($sformatf("req_o&gnt_i[%0d]", k), hits[k] != 0, bankReq[k] & bankGnt[k]);
    end
    gntTotal += $countones(gnt);
    hsTotal  += $countones(bankReq & bankGnt);
    prevGnt  = gnt;
    prevAddr = addr;
  endtask

  task automatic drawTraffic(output logic [NumMasters-1:0] reqV,
                             output bankAddrT [NumMasters-1:0] addrV,
                             output dataT [NumMasters-1:0] wdataV);
    for (int m = 0; m < NumMasters; m++) begin
      reqV[m]   = $urandom_range(0, 9) < 7;
      addrV[m]  = bankAddrT'($urandom);
      wdataV[m] = $urandom;
    end
  endtask

  function automatic logic [NumBanks-1:0] drawBankGnt();
    logic [NumBanks-1:0] g;
    for (int k = 0; k < NumBanks; k++) begin
      g[k] = $urandom_range(0, 3) != 0;
    end
    return g;
  endfunction

  task automatic endTest(string name);
    $display("test %s: %0d errors", name, errCnt - testErrStart);
    testErrStart = errCnt;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    logic [NumMasters-1:0]     reqV;
    bankAddrT [NumMasters-1:0] addrV;
    dataT [NumMasters-1:0]     wdataV;
    logic [NumBanks-1:0]       gntV;

    void'($urandom(70223));
    rstN = 1'b0;
    req = '0;
    addr = '0;
    wdata = '0;
    bankGnt = '0;
    bankRdata = '0;
    prevGnt = '0;
    prevAddr = '0;
    rspCnt = '0;
    errCnt = 0;
    testErrStart = 0;
    gntTotal = 0;
    hsTotal = 0;
    addrV = '0;
    wdataV = '0;
    repeat (ResetCycles) @(posedge clk);
    @(negedge clk);
    rstN = 1'b1;

    repeat (IdleCycles) stepCycle('0, '0, '0, '0, '0);
    endTest("idle after reset");

    // each master alone to each bank, all banks ready
    for (int k = 0; k < NumBanks; k++) begin
      for (int m = 0; m < NumMasters; m++) begin
        reqV = '0;
        reqV[m] = 1'b1;
        addrV[m] = bankAddrT'(k);
        wdataV[m] = $urandom;
        stepCycle(reqV, addrV, wdataV, '1, reqV);
      end
    end
    stepCycle('0, addrV, wdataV, '1, '0);
    endTest("lone request per bank");

    repeat (RandCycles) begin
      drawTraffic(reqV, addrV, wdataV);
      stepCycle(reqV, addrV, wdataV, drawBankGnt(), '0);
    end
    endTest("random contention");

    // one bank holds gnt_i low for a stretch
    for (int k = 0; k < NumBanks; k++) begin
      repeat (BlockCycles / NumBanks) begin
        drawTraffic(reqV, addrV, wdataV);
        gntV = drawBankGnt();
        gntV[k] = 1'b0;
        stepCycle(reqV, addrV, wdataV, gntV, '0);
      end
    end
    endTest("blocked bank");

    if (gntTotal != hsTotal) begin
      errCnt++;
      $display("grant count %0d does not match bank handshake count %0d", gntTotal, hsTotal);
    end
    $display("tests finished: %0d errors, %0d grants, %0d bank handshakes",
             errCnt, gntTotal, hsTotal);
    if (errCnt == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  // watchdog sized from the total cycle count
  initial begin
    #(WatchdogNs);
    $display("watchdog expired at %0t, the tests did not finish", $time);
    $display("Done: errors found");
    $finish;
  end

endmodule

//--- closNet.f
source/closCfgPkg.sv
source/closTypesPkg.sv
source/priorityCounter.sv
source/ingressNode.sv
source/crossbarNode.sv
source/closNet.sv
sim/closNet_props.sv
sim/closNetTb.sv

//--- Makefile
# Verilator build and run of the Clos interconnect testbench

SRCS := $(shell grep -v '^+' closNet.f)

.PHONY: all run check clean

all: check

obj_dir/VclosNetTb: closNet.f $(SRCS)
	verilator --binary --timing --assert -j 0 --top-module closNetTb \
		-f closNet.f -o VclosNetTb

sim.log: obj_dir/VclosNetTb
	./obj_dir/VclosNetTb > sim.log || true

run: sim.log
	cat sim.log

check: run
	grep -q "Done: no errors" sim.log

clean:
	rm -rf obj_dir sim.log
